//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rdma_wr_mux
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/rdma_cfg_pkg.sv
package rdma_cfg_pkg;

    // ------------------------------------------------------------------
    // Data stream geometry
    // ------------------------------------------------------------------

    // Beat width, reduced from the full network bus
    localparam int DATA_BITS     = 64;
    // Bytes per beat
    localparam int KEEP_BITS     = DATA_BITS / 8;
    // Byte offset bits within a beat
    localparam int BEAT_LOG_BITS = $clog2(KEEP_BITS);

    // ------------------------------------------------------------------
    // Queue depths
    // ------------------------------------------------------------------

    // Sequence queue and each meta FIFO
    localparam int N_OUTSTANDING   = 4;
    // Each data FIFO
    localparam int DATA_FIFO_DEPTH = 16;

endpackage

//--- hdl/rdma_req_pkg.sv
package rdma_req_pkg;

    // ------------------------------------------------------------------
    // Write command fields
    // ------------------------------------------------------------------

    // Process id, also used as the stream tid
    localparam int PID_BITS   = 6;
    // Byte length of the payload
    localparam int LEN_BITS   = 16;
    // Virtual address
    localparam int VADDR_BITS = 48;

    // Sequence entry, {host, pid, len}
    localparam int SEQ_BITS  = 1 + PID_BITS + LEN_BITS;

    // Meta entry, {pid, len, vaddr}
    localparam int META_BITS = PID_BITS + LEN_BITS + VADDR_BITS;

    // Beat counter width
    // Holds the beat count of a maximum length command
    localparam int BEAT_CNT_BITS = LEN_BITS - rdma_cfg_pkg::BEAT_LOG_BITS + 1;

endpackage

//--- hdl/rdma_wr_mux.sv
`timescale 1ns/10ps

module rdma_wr_mux (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    // Write commands
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic                                 req_host,
    input  logic [rdma_req_pkg::PID_BITS-1:0]    req_pid,
    input  logic [rdma_req_pkg::LEN_BITS-1:0]    req_len,
    input  logic [rdma_req_pkg::VADDR_BITS-1:0]  req_vaddr,

    // Shared payload stream
    input  logic                                 s_data_valid,
    output logic                                 s_data_ready,
    input  logic [rdma_cfg_pkg::DATA_BITS-1:0]   s_data_tdata,
    input  logic [rdma_cfg_pkg::KEEP_BITS-1:0]   s_data_tkeep,
    input  logic [rdma_req_pkg::PID_BITS-1:0]    s_data_tid,
    input  logic                                 s_data_tlast,

    // SEND meta out
    output logic                                 rq_meta_valid,
    input  logic                                 rq_meta_ready,
    output logic [rdma_req_pkg::PID_BITS-1:0]    rq_meta_pid,
    output logic [rdma_req_pkg::LEN_BITS-1:0]    rq_meta_len,
    output logic [rdma_req_pkg::VADDR_BITS-1:0]  rq_meta_vaddr,

    // WRITE meta out
    output logic                                 wr_meta_valid,
    input  logic                                 wr_meta_ready,
    output logic [rdma_req_pkg::PID_BITS-1:0]    wr_meta_pid,
    output logic [rdma_req_pkg::LEN_BITS-1:0]    wr_meta_len,
    output logic [rdma_req_pkg::VADDR_BITS-1:0]  wr_meta_vaddr,

    // SEND data out
    output logic                                 rq_data_valid,
    input  logic                                 rq_data_ready,
    output logic [rdma_cfg_pkg::DATA_BITS-1:0]   rq_data_tdata,
    output logic [rdma_cfg_pkg::KEEP_BITS-1:0]   rq_data_tkeep,
    output logic [rdma_req_pkg::PID_BITS-1:0]    rq_data_tid,
    output logic                                 rq_data_tlast,

    // WRITE data out
    output logic                                 wr_data_valid,
    input  logic                                 wr_data_ready,
    output logic [rdma_cfg_pkg::DATA_BITS-1:0]   wr_data_tdata,
    output logic [rdma_cfg_pkg::KEEP_BITS-1:0]   wr_data_tkeep,
    output logic [rdma_req_pkg::PID_BITS-1:0]    wr_data_tid,
    output logic                                 wr_data_tlast
);

    // Sequence queue
    logic                              seq_push_valid;
    logic                              seq_push_ready;
    logic [rdma_req_pkg::SEQ_BITS-1:0] seq_push_data;
    logic                              seq_pop_valid;
    logic                              seq_pop_ready;
    logic [rdma_req_pkg::SEQ_BITS-1:0] seq_pop_data;

    // Steered beats into the data FIFOs
    logic                               steer_rq_valid;
    logic                               steer_rq_ready;
    logic                               steer_wr_valid;
    logic                               steer_wr_ready;
    logic [rdma_cfg_pkg::DATA_BITS-1:0] steer_tdata;
    logic [rdma_cfg_pkg::KEEP_BITS-1:0] steer_tkeep;
    logic [rdma_req_pkg::PID_BITS-1:0]  steer_tid;
    logic                               steer_tlast;

    // ------------------------------------------------------------------
    // Command split
    // ------------------------------------------------------------------
    wr_cmd_split u_cmd_split (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_host       (req_host),
        .req_pid        (req_pid),
        .req_len        (req_len),
        .req_vaddr      (req_vaddr),
        .seq_push_valid (seq_push_valid),
        .seq_push_ready (seq_push_ready),
        .seq_push_data  (seq_push_data),
        .rq_meta_valid  (rq_meta_valid),
        .rq_meta_ready  (rq_meta_ready),
        .rq_meta_pid    (rq_meta_pid),
        .rq_meta_len    (rq_meta_len),
        .rq_meta_vaddr  (rq_meta_vaddr),
        .wr_meta_valid  (wr_meta_valid),
        .wr_meta_ready  (wr_meta_ready),
        .wr_meta_pid    (wr_meta_pid),
        .wr_meta_len    (wr_meta_len),
        .wr_meta_vaddr  (wr_meta_vaddr)
    );

    // Command order for the data side
    sync_fifo #(
        .WIDTH (rdma_req_pkg::SEQ_BITS),
        .DEPTH (rdma_cfg_pkg::N_OUTSTANDING)
    ) u_seq_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (seq_push_valid),
        .in_ready  (seq_push_ready),
        .in_data   (seq_push_data),
        .out_valid (seq_pop_valid),
        .out_ready (seq_pop_ready),
        .out_data  (seq_pop_data)
    );

    // ------------------------------------------------------------------
    // Data steering
    // ------------------------------------------------------------------
    wr_data_steer u_data_steer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .seq_pop_valid  (seq_pop_valid),
        .seq_pop_ready  (seq_pop_ready),
        .seq_pop_data   (seq_pop_data),
        .s_data_valid   (s_data_valid),
        .s_data_ready   (s_data_ready),
        .s_data_tdata   (s_data_tdata),
        .s_data_tkeep   (s_data_tkeep),
        .s_data_tid     (s_data_tid),
        .s_data_tlast   (s_data_tlast),
        .steer_rq_valid (steer_rq_valid),
        .steer_rq_ready (steer_rq_ready),
        .steer_wr_valid (steer_wr_valid),
        .steer_wr_ready (steer_wr_ready),
        .steer_tdata    (steer_tdata),
        .steer_tkeep    (steer_tkeep),
        .steer_tid      (steer_tid),
        .steer_tlast    (steer_tlast)
    );

    // Beat word {tdata, tkeep, tid, tlast}
    sync_fifo #(
        .WIDTH (rdma_cfg_pkg::DATA_BITS + rdma_cfg_pkg::KEEP_BITS + rdma_req_pkg::PID_BITS + 1),
        .DEPTH (rdma_cfg_pkg::DATA_FIFO_DEPTH)
    ) u_rq_data (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (steer_rq_valid),
        .in_ready  (steer_rq_ready),
        .in_data   ({steer_tdata, steer_tkeep, steer_tid, steer_tlast}),
        .out_valid (rq_data_valid),
        .out_ready (rq_data_ready),
        .out_data  ({rq_data_tdata, rq_data_tkeep, rq_data_tid, rq_data_tlast})
    );

    sync_fifo #(
        .WIDTH (rdma_cfg_pkg::DATA_BITS + rdma_cfg_pkg::KEEP_BITS + rdma_req_pkg::PID_BITS + 1),
        .DEPTH (rdma_cfg_pkg::DATA_FIFO_DEPTH)
    ) u_wr_data (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (steer_wr_valid),
        .in_ready  (steer_wr_ready),
        .in_data   ({steer_tdata, steer_tkeep, steer_tid, steer_tlast}),
        .out_valid (wr_data_valid),
        .out_ready (wr_data_ready),
        .out_data  ({wr_data_tdata, wr_data_tkeep, wr_data_tid, wr_data_tlast})
    );

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,

    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    // Storage, no reset
    logic [WIDTH-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    // Entries held in mem, not counting the output register
    logic [$clog2(DEPTH+1)-1:0] count;

    logic push;
    logic pop;

    // Move head of mem into the output register when it is free
    assign pop  = (count != '0) && (!out_valid || out_ready);
    // A full buffer still takes a word when the head moves out
    assign in_ready = (count != ($clog2(DEPTH+1))'(DEPTH)) || pop;
    assign push = in_valid && in_ready;

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // Both or neither leaves count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // ------------------------------------------------------------------
    // Registered output
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

    // Occupancy bound
    a_count_max: assert property (@(posedge aclk) disable iff (!aresetn)
        count <= ($clog2(DEPTH+1))'(DEPTH));

    // Stalled output word holds
    a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

//--- hdl/wr_cmd_split.sv
`timescale 1ns/10ps

module wr_cmd_split (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    // Incoming write command
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic                                 req_host,
    input  logic [rdma_req_pkg::PID_BITS-1:0]    req_pid,
    input  logic [rdma_req_pkg::LEN_BITS-1:0]    req_len,
    input  logic [rdma_req_pkg::VADDR_BITS-1:0]  req_vaddr,

    // Sequence queue push
    output logic                                 seq_push_valid,
    input  logic                                 seq_push_ready,
    output logic [rdma_req_pkg::SEQ_BITS-1:0]    seq_push_data,

    // SEND meta
    output logic                                 rq_meta_valid,
    input  logic                                 rq_meta_ready,
    output logic [rdma_req_pkg::PID_BITS-1:0]    rq_meta_pid,
    output logic [rdma_req_pkg::LEN_BITS-1:0]    rq_meta_len,
    output logic [rdma_req_pkg::VADDR_BITS-1:0]  rq_meta_vaddr,

    // WRITE meta
    output logic                                 wr_meta_valid,
    input  logic                                 wr_meta_ready,
    output logic [rdma_req_pkg::PID_BITS-1:0]    wr_meta_pid,
    output logic [rdma_req_pkg::LEN_BITS-1:0]    wr_meta_len,
    output logic [rdma_req_pkg::VADDR_BITS-1:0]  wr_meta_vaddr
);

    logic rq_push_valid;
    logic rq_push_ready;
    logic wr_push_valid;
    logic wr_push_ready;
    logic path_ready;
    // Low through reset and the cycle after it
    logic accept_en;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            accept_en <= 1'b0;
        end else begin
            accept_en <= 1'b1;
        end
    end

    // Meta FIFO picked by the host bit
    assign path_ready = req_host ? wr_push_ready : rq_push_ready;

    // Both queues or neither
    assign req_ready      = accept_en && seq_push_ready && path_ready;
    assign seq_push_valid = req_valid && req_ready;
    assign seq_push_data  = {req_host, req_pid, req_len};

    assign rq_push_valid = seq_push_valid && !req_host;
    assign wr_push_valid = seq_push_valid && req_host;

    // SEND path, host bit clear
    sync_fifo #(
        .WIDTH (rdma_req_pkg::META_BITS),
        .DEPTH (rdma_cfg_pkg::N_OUTSTANDING)
    ) u_rq_meta (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (rq_push_valid),
        .in_ready  (rq_push_ready),
        .in_data   ({req_pid, req_len, req_vaddr}),
        .out_valid (rq_meta_valid),
        .out_ready (rq_meta_ready),
        .out_data  ({rq_meta_pid, rq_meta_len, rq_meta_vaddr})
    );

    // WRITE path, host bit set
    sync_fifo #(
        .WIDTH (rdma_req_pkg::META_BITS),
        .DEPTH (rdma_cfg_pkg::N_OUTSTANDING)
    ) u_wr_meta (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (wr_push_valid),
        .in_ready  (wr_push_ready),
        .in_data   ({req_pid, req_len, req_vaddr}),
        .out_valid (wr_meta_valid),
        .out_ready (wr_meta_ready),
        .out_data  ({wr_meta_pid, wr_meta_len, wr_meta_vaddr})
    );

    // Zero-length commands are illegal
    a_len_nonzero: assert property (@(posedge aclk) disable iff (!aresetn)
        (req_valid && req_ready) |-> (req_len != '0));

    // Sequence push exactly when one meta FIFO takes the command
    a_push_pair: assert property (@(posedge aclk) disable iff (!aresetn)
        (seq_push_valid && seq_push_ready) ==
            ((rq_push_valid && rq_push_ready) || (wr_push_valid && wr_push_ready)));

endmodule

//--- hdl/wr_data_steer.sv
`timescale 1ns/10ps

module wr_data_steer (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    // Sequence queue pop, {host, pid, len}
    input  logic                                 seq_pop_valid,
    output logic                                 seq_pop_ready,
    input  logic [rdma_req_pkg::SEQ_BITS-1:0]    seq_pop_data,

    // Shared input stream
    input  logic                                 s_data_valid,
    output logic                                 s_data_ready,
    input  logic [rdma_cfg_pkg::DATA_BITS-1:0]   s_data_tdata,
    input  logic [rdma_cfg_pkg::KEEP_BITS-1:0]   s_data_tkeep,
    input  logic [rdma_req_pkg::PID_BITS-1:0]    s_data_tid,
    input  logic                                 s_data_tlast,

    // Per path handshake
    output logic                                 steer_rq_valid,
    input  logic                                 steer_rq_ready,
    output logic                                 steer_wr_valid,
    input  logic                                 steer_wr_ready,

    // Beat payload, common to both paths
    output logic [rdma_cfg_pkg::DATA_BITS-1:0]   steer_tdata,
    output logic [rdma_cfg_pkg::KEEP_BITS-1:0]   steer_tkeep,
    output logic [rdma_req_pkg::PID_BITS-1:0]    steer_tid,
    output logic                                 steer_tlast
);

    typedef enum logic {
        ST_IDLE,
        ST_STEER
    } state_t;

    state_t state_q;
    state_t state_d;

    // Selected path, 1 for WRITE
    logic host_q;
    logic host_d;
    // Beats left in the current command
    logic [rdma_req_pkg::BEAT_CNT_BITS-1:0] cnt_q;
    logic [rdma_req_pkg::BEAT_CNT_BITS-1:0] cnt_d;

    logic                                   next_host;
    logic [rdma_req_pkg::LEN_BITS-1:0]      next_len;
    logic [rdma_req_pkg::BEAT_CNT_BITS-1:0] next_beats;

    logic beat_acc;
    logic last_beat;

    // ------------------------------------------------------------------
    // Head of the sequence queue
    // ------------------------------------------------------------------
    assign next_host = seq_pop_data[rdma_req_pkg::SEQ_BITS-1];
    assign next_len  = seq_pop_data[rdma_req_pkg::LEN_BITS-1:0];

    // Beats = ceil(len / KEEP_BITS)
    assign next_beats =
        (rdma_req_pkg::BEAT_CNT_BITS)'(next_len >> rdma_cfg_pkg::BEAT_LOG_BITS) +
        (rdma_req_pkg::BEAT_CNT_BITS)'(next_len[rdma_cfg_pkg::BEAT_LOG_BITS-1:0] != '0);

    assign beat_acc  = s_data_valid && s_data_ready;
    assign last_beat = (cnt_q == (rdma_req_pkg::BEAT_CNT_BITS)'(1));

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        host_d        = host_q;
        cnt_d         = cnt_q;
        seq_pop_ready = 1'b0;
        case (state_q)
            ST_IDLE: begin
                seq_pop_ready = 1'b1;
                if (seq_pop_valid) begin
                    state_d = ST_STEER;
                    host_d  = next_host;
                    cnt_d   = next_beats;
                end
            end
            ST_STEER: begin
                if (beat_acc && last_beat) begin
                    // Back to back commands, no idle cycle
                    seq_pop_ready = 1'b1;
                    if (seq_pop_valid) begin
                        host_d = next_host;
                        cnt_d  = next_beats;
                    end else begin
                        state_d = ST_IDLE;
                    end
                end else if (beat_acc) begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
            host_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            host_q  <= host_d;
            cnt_q   <= cnt_d;
        end
    end

    // ------------------------------------------------------------------
    // Steering
    // ------------------------------------------------------------------
    assign steer_rq_valid = (state_q == ST_STEER) && !host_q && s_data_valid;
    assign steer_wr_valid = (state_q == ST_STEER) && host_q && s_data_valid;

    // Only the selected FIFO can stall the input
    assign s_data_ready = (state_q == ST_STEER) && (host_q ? steer_wr_ready : steer_rq_ready);

    assign steer_tdata = s_data_tdata;
    assign steer_tkeep = s_data_tkeep;
    assign steer_tid   = s_data_tid;
    assign steer_tlast = s_data_tlast;

    // Stream framing must agree with the command length
    a_tlast_match: assert property (@(posedge aclk) disable iff (!aresetn)
        beat_acc |-> (s_data_tlast == last_beat));

endmodule

//--- sim.f
hdl/rdma_cfg_pkg.sv
hdl/rdma_req_pkg.sv
hdl/sync_fifo.sv
hdl/wr_cmd_split.sv
hdl/wr_data_steer.sv
hdl/rdma_wr_mux.sv
tests/tb_rdma_wr_mux.sv

//--- tests/tb_rdma_wr_mux.sv
`timescale 1ns/10ps

module tb_rdma_wr_mux;

    localparam int PID_W   = rdma_req_pkg::PID_BITS;
    localparam int LEN_W   = rdma_req_pkg::LEN_BITS;
    localparam int VADDR_W = rdma_req_pkg::VADDR_BITS;
    localparam int META_W  = rdma_req_pkg::META_BITS;
    localparam int DATA_W  = rdma_cfg_pkg::DATA_BITS;
    localparam int KEEP_W  = rdma_cfg_pkg::KEEP_BITS;
    // Beat word {tdata, tkeep, tid, tlast}
    localparam int BEAT_W  = DATA_W + KEEP_W + PID_W + 1;

    localparam int N_CMDS     = 200;
    localparam int WAIT_LIMIT = 2000;
    // Cycles per back-pressure phase
    localparam int PHASE_LEN  = 150;

    logic               aclk;
    logic               aresetn;
    logic               req_valid;
    logic               req_ready;
    logic               req_host;
    logic [PID_W-1:0]   req_pid;
    logic [LEN_W-1:0]   req_len;
    logic [VADDR_W-1:0] req_vaddr;
    logic               s_data_valid;
    logic               s_data_ready;
    logic [DATA_W-1:0]  s_data_tdata;
    logic [KEEP_W-1:0]  s_data_tkeep;
    logic [PID_W-1:0]   s_data_tid;
    logic               s_data_tlast;
    logic               rq_meta_valid;
    logic               rq_meta_ready;
    logic [PID_W-1:0]   rq_meta_pid;
    logic [LEN_W-1:0]   rq_meta_len;
    logic [VADDR_W-1:0] rq_meta_vaddr;
    logic               wr_meta_valid;
    logic               wr_meta_ready;
    logic [PID_W-1:0]   wr_meta_pid;
    logic [LEN_W-1:0]   wr_meta_len;
    logic [VADDR_W-1:0] wr_meta_vaddr;
    logic               rq_data_valid;
    logic               rq_data_ready;
    logic [DATA_W-1:0]  rq_data_tdata;
    logic [KEEP_W-1:0]  rq_data_tkeep;
    logic [PID_W-1:0]   rq_data_tid;
    logic               rq_data_tlast;
    logic               wr_data_valid;
    logic               wr_data_ready;
    logic [DATA_W-1:0]  wr_data_tdata;
    logic [KEEP_W-1:0]  wr_data_tkeep;
    logic [PID_W-1:0]   wr_data_tid;
    logic               wr_data_tlast;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    logic [META_W-1:0] exp_rq_meta[$];
    logic [META_W-1:0] exp_wr_meta[$];
    logic [BEAT_W-1:0] exp_rq_beat[$];
    logic [BEAT_W-1:0] exp_wr_beat[$];
    // Accepted commands still owed payload, {host, len}
    logic [LEN_W:0]    payload_q[$];

    int cyc = 0;
    int phase = 0;

    // Port names match one to one
    rdma_wr_mux dut (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic stop_failed();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: time %0d ns: %s mismatch, got %0h expected %0h",
                     $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic expect_idle(input string when);
        compare_value($sformatf("req_ready %s", when), 64'(req_ready), 64'(0));
        compare_value($sformatf("s_data_ready %s", when), 64'(s_data_ready), 64'(0));
        compare_value($sformatf("rq_meta_valid %s", when), 64'(rq_meta_valid), 64'(0));
        compare_value($sformatf("wr_meta_valid %s", when), 64'(wr_meta_valid), 64'(0));
        compare_value($sformatf("rq_data_valid %s", when), 64'(rq_data_valid), 64'(0));
        compare_value($sformatf("wr_data_valid %s", when), 64'(wr_data_valid), 64'(0));
    endtask

    task automatic meta_arrival(input logic host, input logic [PID_W-1:0] pid,
                                input logic [LEN_W-1:0] len, input logic [VADDR_W-1:0] vaddr);
        logic [PID_W-1:0]   e_pid;
        logic [LEN_W-1:0]   e_len;
        logic [VADDR_W-1:0] e_vaddr;
        string              path;
        path = host ? "wr_meta" : "rq_meta";
        if ((host ? exp_wr_meta.size() : exp_rq_meta.size()) == 0) begin
            $display("%s put out a command that was never sent to it, at %0d ns", path, $time);
            stop_failed();
        end else begin
            if (host) begin
                {e_pid, e_len, e_vaddr} = exp_wr_meta.pop_front();
            end else begin
                {e_pid, e_len, e_vaddr} = exp_rq_meta.pop_front();
            end
            compare_value($sformatf("%s pid", path), 64'(pid), 64'(e_pid));
            compare_value($sformatf("%s len", path), 64'(len), 64'(e_len));
            compare_value($sformatf("%s vaddr", path), 64'(vaddr), 64'(e_vaddr));
        end
    endtask

    task automatic beat_arrival(input logic host, input logic [DATA_W-1:0] tdata,
                                input logic [KEEP_W-1:0] tkeep, input logic [PID_W-1:0] tid,
                                input logic tlast);
        logic [DATA_W-1:0] e_tdata;
        logic [KEEP_W-1:0] e_tkeep;
        logic [PID_W-1:0]  e_tid;
        logic              e_tlast;
        string             path;
        path = host ? "wr_data" : "rq_data";
        if ((host ? exp_wr_beat.size() : exp_rq_beat.size()) == 0) begin
            $display("%s put out a beat that was never steered to it, at %0d ns", path, $time);
            stop_failed();
        end else begin
            if (host) begin
                {e_tdata, e_tkeep, e_tid, e_tlast} = exp_wr_beat.pop_front();
            end else begin
                {e_tdata, e_tkeep, e_tid, e_tlast} = exp_rq_beat.pop_front();
            end
            compare_value($sformatf("%s tdata", path), 64'(tdata), 64'(e_tdata));
            compare_value($sformatf("%s tkeep", path), 64'(tkeep), 64'(e_tkeep));
            compare_value($sformatf("%s tid", path), 64'(tid), 64'(e_tid));
            compare_value($sformatf("%s tlast", path), 64'(tlast), 64'(e_tlast));
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic issue_commands();
        logic               host;
        logic [PID_W-1:0]   pid;
        logic [LEN_W-1:0]   len;
        logic [VADDR_W-1:0] vaddr;
        int                 waited;
        for (int n = 0; n < N_CMDS; n++) begin
            host  = 1'($urandom());
            pid   = PID_W'($urandom());
            len   = LEN_W'(1 + ($urandom() % 64));
            vaddr = VADDR_W'({$urandom(), $urandom()});
            req_valid = 1'b1;
            req_host  = host;
            req_pid   = pid;
            req_len   = len;
            req_vaddr = vaddr;
            // Ready seen mid cycle means transfer on the next edge
            waited = 0;
            @(negedge aclk);
            while (!req_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timeout: command %0d was never accepted", n);
                    stop_failed();
                end
                @(negedge aclk);
            end
            if (host) begin
                exp_wr_meta.push_back({pid, len, vaddr});
            end else begin
                exp_rq_meta.push_back({pid, len, vaddr});
            end
            payload_q.push_back({host, len});
            @(posedge aclk);
            #1;
            req_valid = 1'b0;
            // Occasional gap between commands
            if ($urandom() % 4 == 0) begin
                @(posedge aclk);
                #1;
            end
        end
    endtask

    task automatic stream_payload();
        logic             host;
        logic [LEN_W-1:0] len;
        int               beats;
        int               waited;
        for (int n = 0; n < N_CMDS; n++) begin
            waited = 0;
            while (payload_q.size() == 0) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timeout: no accepted command to send payload %0d for", n);
                    stop_failed();
                end
                @(posedge aclk);
                #1;
            end
            {host, len} = payload_q.pop_front();
            // Ceiling of len over bytes per beat
            beats = (int'(len) + KEEP_W - 1) / KEEP_W;
            for (int b = 0; b < beats; b++) begin
                s_data_valid = 1'b1;
                s_data_tdata = DATA_W'({$urandom(), $urandom()});
                s_data_tkeep = KEEP_W'($urandom());
                s_data_tid   = PID_W'($urandom());
                s_data_tlast = (b == beats - 1);
                waited = 0;
                @(negedge aclk);
                while (!s_data_ready) begin
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        $display("timeout: beat %0d of command %0d was never accepted", b, n);
                        stop_failed();
                    end
                    @(negedge aclk);
                end
                if (host) begin
                    exp_wr_beat.push_back({s_data_tdata, s_data_tkeep, s_data_tid, s_data_tlast});
                end else begin
                    exp_rq_beat.push_back({s_data_tdata, s_data_tkeep, s_data_tid, s_data_tlast});
                end
                @(posedge aclk);
                #1;
                s_data_valid = 1'b0;
                if ($urandom() % 8 == 0) begin
                    @(posedge aclk);
                    #1;
                end
            end
        end
    endtask

    // Output back-pressure, about 70% ready
    // Phase 1 stalls the rq side, phase 3 the wr side
    initial begin
        rq_meta_ready = 1'b0;
        wr_meta_ready = 1'b0;
        rq_data_ready = 1'b0;
        wr_data_ready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            if (aresetn) begin
                phase = (cyc / PHASE_LEN) % 4;
                rq_meta_ready = (phase != 1) && (($urandom() % 100) < 70);
                rq_data_ready = (phase != 1) && (($urandom() % 100) < 70);
                wr_meta_ready = (phase != 3) && (($urandom() % 100) < 70);
                wr_data_ready = (phase != 3) && (($urandom() % 100) < 70);
                cyc++;
            end
        end
    end

    // Outputs sampled mid cycle, away from the edge
    always @(negedge aclk) begin
        if (aresetn) begin
            if (rq_meta_valid && rq_meta_ready) begin
                meta_arrival(1'b0, rq_meta_pid, rq_meta_len, rq_meta_vaddr);
            end
            if (wr_meta_valid && wr_meta_ready) begin
                meta_arrival(1'b1, wr_meta_pid, wr_meta_len, wr_meta_vaddr);
            end
            if (rq_data_valid && rq_data_ready) begin
                beat_arrival(1'b0, rq_data_tdata, rq_data_tkeep, rq_data_tid, rq_data_tlast);
            end
            if (wr_data_valid && wr_data_ready) begin
                beat_arrival(1'b1, wr_data_tdata, wr_data_tkeep, wr_data_tid, wr_data_tlast);
            end
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int waited;
        void'($urandom(32'h3a0d));
        aresetn      = 1'b0;
        req_valid    = 1'b0;
        req_host     = 1'b0;
        req_pid      = '0;
        req_len      = '0;
        req_vaddr    = '0;
        s_data_valid = 1'b0;
        s_data_tdata = '0;
        s_data_tkeep = '0;
        s_data_tid   = '0;
        s_data_tlast = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge aclk);
            #1;
            expect_idle("during reset");
        end
        aresetn = 1'b1;
        @(negedge aclk);
        expect_idle("after reset");
        @(posedge aclk);
        #1;
        fork
            issue_commands();
            stream_payload();
        join
        // Drain whatever is still buffered
        waited = 0;
        while (exp_rq_meta.size() + exp_wr_meta.size() +
               exp_rq_beat.size() + exp_wr_beat.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: outputs did not drain, commands or beats are missing");
                stop_failed();
            end
            @(posedge aclk);
        end
        // Any word still in a FIFO reaches its output register within a cycle
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        compare_value("rq_meta_valid after drain", 64'(rq_meta_valid), 64'(0));
        compare_value("wr_meta_valid after drain", 64'(wr_meta_valid), 64'(0));
        compare_value("rq_data_valid after drain", 64'(rq_data_valid), 64'(0));
        compare_value("wr_data_valid after drain", 64'(wr_data_valid), 64'(0));
        $display("*** PASSED ***");
        $finish;
    end

endmodule
